// ==== vlog.f ====
verilog/md5_pkg.sv
verilog/md5_step.sv
verilog/md5_core.sv
verilog/md5_channel.sv
verilog/md5_accel_top.sv
test/md5_ref_pkg.sv
test/md5_accel_tb.sv

// ==== Bender.yml ====
package:
  name: md5_accel

dependencies: {}

sources:
  # Package first, then leaf modules and the top level
  - files:
      - verilog/md5_pkg.sv
      - verilog/md5_step.sv
      - verilog/md5_core.sv
      - verilog/md5_channel.sv
      - verilog/md5_accel_top.sv

  # Reference model and testbench
  - target: test
    files:
      - test/md5_ref_pkg.sv
      - test/md5_accel_tb.sv

// ==== test/md5_accel_tb.sv ====
// MD5 accelerator testbench: clock, reset, random messages, output monitor, checks, watchdog
`default_nettype none

module md5_accel_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// --------------------------------------------------
	// Test lengths and limits
	// --------------------------------------------------
	localparam logic [31:0]  SEED       = 32'hc95895ff;
	localparam int           N_RANDOM   = 8;
	// abc, restart pair, then up to four blocks per random message
	localparam int           MAX_BLOCKS = 1 + 3 + 4 * N_RANDOM;
	// Byte and block budget tripled for the random stalls
	localparam int           TIMEOUT_NS = 3 * (MAX_BLOCKS * 64 * 4 + MAX_BLOCKS * 80 * 4) + 2000;
	localparam logic [127:0] ABC_DIGEST = 128'h900150983cd24fb0d6963f7d28e17f72;

	logic         clk;
	logic         rst;
	logic         wen;
	logic         ren;
	logic         in_sof;
	logic         in_eof;
	logic         in_src_rdy;
	logic [7:0]   in_data;
	logic         in_dst_rdy;
	logic         out_dst_rdy;
	logic         out_sof;
	logic         out_eof;
	logic         out_src_rdy;
	logic [7:0]   out_data;

	// Blocks of the next message, expected frames and their test names
	logic [511:0] blk_q [$];
	logic [127:0] exp_q [$];
	string        name_q [$];
	int           value_errs;
	int           proto_errs;
	int           frames_seen;
	int           frames_sent;

	md5_accel_top dut (
		.clk           (clk),
		.rst           (rst),
		.wen_i         (wen),
		.ren_i         (ren),
		.in_sof_i      (in_sof),
		.in_eof_i      (in_eof),
		.in_src_rdy_i  (in_src_rdy),
		.in_data_i     (in_data),
		.in_dst_rdy_o  (in_dst_rdy),
		.out_dst_rdy_i (out_dst_rdy),
		.out_sof_o     (out_sof),
		.out_eof_o     (out_eof),
		.out_src_rdy_o (out_src_rdy),
		.out_data_o    (out_data)
	);

	always #2 clk = ~clk;

	function automatic logic [511:0] random_block();
		logic [511:0] b;
		for (int w = 0; w < 16; w++)
			b = {b[479:0], $urandom};
		return b;
	endfunction

	// --------------------------------------------------
	// Message driver
	// --------------------------------------------------
	// Queues one expected frame per block, then streams the bytes with gaps
	task automatic send_message(input string name);
		logic [127:0] st;
		logic [511:0] blk;
		int           nbytes;
		logic         took;
		st = md5_ref_pkg::init_state();
		for (int k = 0; k < blk_q.size(); k++)
		begin
			st = md5_ref_pkg::compress(st, blk_q[k]);
			exp_q.push_back(md5_ref_pkg::digest_bytes(st));
			name_q.push_back(name);
		end
		frames_sent += blk_q.size();
		nbytes = 64 * blk_q.size();
		for (int n = 0; n < nbytes; n++)
		begin
			blk     = blk_q[n / 64];
			in_data = blk[511 - 8 * (n % 64) -: 8];
			in_sof  = (n == 0);
			in_eof  = (n == nbytes - 1);
			// Hold the byte until the channel takes it
			do
			begin
				in_src_rdy = ($urandom % 4) != 0;
				wen        = ($urandom % 6) != 0;
				@(negedge clk);
				took = in_src_rdy && wen && in_dst_rdy;
				@(posedge clk);
				#0.5;
			end
			while (!took);
		end
		in_src_rdy = 1'b0;
		wen        = 1'b0;
		blk_q.delete();
	endtask

	// --------------------------------------------------
	// Output monitor
	// --------------------------------------------------
	initial
	begin : monitor
		logic [127:0] frame;
		logic [127:0] exp;
		string        name;
		int           idx;
		idx   = 0;
		frame = '0;
		@(negedge rst);
		forever
		begin
			@(posedge clk);
			#0.5;
			out_dst_rdy = ($urandom % 3) != 0;
			ren         = ($urandom % 5) != 0;
			// Transfer decided by levels held since the drive point
			@(negedge clk);
			if (out_src_rdy && out_dst_rdy && ren)
			begin
				assert (out_sof == (idx == 0) && out_eof == (idx == 15))
				else
				begin
					proto_errs++;
					$display("Framing fault at byte %0d of a frame: sof %b, eof %b",
						idx, out_sof, out_eof);
				end
				frame = {frame[119:0], out_data};
				idx++;
				if (idx == 16)
				begin
					idx = 0;
					frames_seen++;
					assert (exp_q.size() > 0)
					else
					begin
						proto_errs++;
						$display("Output frame arrived with no block sent for it");
					end
					if (exp_q.size() > 0)
					begin
						exp  = exp_q.pop_front();
						name = name_q.pop_front();
						assert (frame == exp)
						else
						begin
							value_errs++;
							$display("ERR %s: expected %h, actual %h", name, exp, frame);
						end
					end
				end
			end
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin : stimulus
		logic [511:0] first;
		logic [127:0] st;
		int           nblk;
		clk         = 1'b0;
		rst         = 1'b1;
		wen         = 1'b0;
		ren         = 1'b0;
		in_sof      = 1'b0;
		in_eof      = 1'b0;
		in_src_rdy  = 1'b0;
		in_data     = 8'h00;
		out_dst_rdy = 1'b0;
		value_errs  = 0;
		proto_errs  = 0;
		frames_seen = 0;
		frames_sent = 0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		#0.5;
		rst = 1'b0;
		// Still one cycle before the channel opens
		@(negedge clk);
		assert (!in_dst_rdy && !out_src_rdy && !out_sof && !out_eof)
		else
		begin
			proto_errs++;
			$display("Control outputs are not low after reset");
		end
		@(posedge clk);
		#0.5;

		// Padded "abc" with the 24-bit length in byte 56
		blk_q.push_back({32'h61626380, 416'h0, 8'h18, 56'h0});
		st = md5_ref_pkg::digest_bytes(md5_ref_pkg::compress(md5_ref_pkg::init_state(), blk_q[0]));
		assert (st == ABC_DIGEST)
		else
		begin
			value_errs++;
			$display("ERR abc_model: expected %h, actual %h", ABC_DIGEST, st);
		end
		send_message("abc");

		// Same first block after other text must give the fresh digest
		first = random_block();
		blk_q.push_back(first);
		blk_q.push_back(random_block());
		send_message("restart_prev");
		blk_q.push_back(first);
		send_message("restart");

		for (int m = 0; m < N_RANDOM; m++)
		begin
			nblk = 1 + $urandom % 4;
			repeat (nblk) blk_q.push_back(random_block());
			send_message($sformatf("random%0d", m));
		end

		wait (frames_seen == frames_sent);
		// Idle stretch to catch a stray extra frame
		repeat (40) @(posedge clk);
		assert (exp_q.size() == 0 && frames_seen == frames_sent)
		else
		begin
			proto_errs++;
			$display("Frame count wrong: %0d received for %0d blocks", frames_seen, frames_sent);
		end
		$display("Errors: %0d value, %0d protocol, over %0d frames",
			value_errs, proto_errs, frames_seen);
		if (value_errs == 0 && proto_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/md5_ref_pkg.sv ====
// MD5 reference model: initial state, block compression and digest byte order
`default_nettype none

package md5_ref_pkg;

	// Sine constant straight from its definition, floor(|sin(i+1)| * 2^32)
	function automatic logic [31:0] sine_const(input int i);
		real r;
		r = $sin(i + 1.0);
		if (r < 0.0)
			r = -r;
		return 32'(longint'($floor(r * 4294967296.0)));
	endfunction

	// Four shift amounts per round, repeating every four steps
	function automatic int shift_amt(input int i);
		int tbl [16];
		tbl = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
		return tbl[(i / 16) * 4 + i % 4];
	endfunction

	function automatic logic [31:0] rotl(input logic [31:0] x, input int s);
		return (x << s) | (x >> (32 - s));
	endfunction

	// Word j from bytes 4j..4j+3, first byte lowest; byte 0 sits in the top bits
	function automatic logic [31:0] msg_word(input logic [511:0] blk, input int j);
		logic [31:0] w;
		for (int n = 0; n < 4; n++)
			w[8*n +: 8] = blk[511 - 8*(4*j + n) -: 8];
		return w;
	endfunction

	// Standard chaining values, a in the top bits
	function automatic logic [127:0] init_state();
		return {32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};
	endfunction

	// One 64-step compression plus the chaining add
	function automatic logic [127:0] compress(input logic [127:0] st, input logic [511:0] blk);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] f;
		logic [31:0] t;
		int          g;
		{a, b, c, d} = st;
		for (int i = 0; i < 64; i++)
		begin
			case (i / 16)
				0:
				begin
					f = (b & c) | (~b & d);
					g = i;
				end
				1:
				begin
					f = (d & b) | (~d & c);
					g = (5 * i + 1) % 16;
				end
				2:
				begin
					f = b ^ c ^ d;
					g = (3 * i + 5) % 16;
				end
				default:
				begin
					f = c ^ (b | ~d);
					g = (7 * i) % 16;
				end
			endcase
			t = d;
			d = c;
			c = b;
			b = b + rotl(a + f + sine_const(i) + msg_word(blk, g), shift_amt(i));
			a = t;
		end
		return {st[127:96] + a, st[95:64] + b, st[63:32] + c, st[31:0] + d};
	endfunction

	// Hex byte order: low byte of a first, byte 0 in the top bits
	function automatic logic [127:0] digest_bytes(input logic [127:0] st);
		logic [127:0] r;
		for (int w = 0; w < 4; w++)
			for (int n = 0; n < 4; n++)
				r[127 - 8*(4*w + n) -: 8] = st[96 - 32*w + 8*n +: 8];
		return r;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/md5_accel_top.sv ====
// MD5 accelerator top: byte stream channel and iterative core
`default_nettype none

module md5_accel_top (
	input  wire        clk,
	input  wire        rst,
	input  wire        wen_i,
	input  wire        ren_i,
	input  wire        in_sof_i,
	input  wire        in_eof_i,
	input  wire        in_src_rdy_i,
	input  wire  [7:0] in_data_i,
	output wire        in_dst_rdy_o,
	input  wire        out_dst_rdy_i,
	output wire        out_sof_o,
	output wire        out_eof_o,
	output wire        out_src_rdy_o,
	output wire  [7:0] out_data_o
);

	// Channel to core
	md5_pkg::md5_chunk_t chunk;
	md5_pkg::md5_state_t digest;
	logic                load;
	logic                busy;
	logic                digest_valid;

	md5_channel u_channel (
		.clk            (clk),
		.rst            (rst),
		.wen_i          (wen_i),
		.ren_i          (ren_i),
		.in_sof_i       (in_sof_i),
		.in_eof_i       (in_eof_i),
		.in_src_rdy_i   (in_src_rdy_i),
		.in_data_i      (in_data_i),
		.in_dst_rdy_o   (in_dst_rdy_o),
		.out_dst_rdy_i  (out_dst_rdy_i),
		.out_sof_o      (out_sof_o),
		.out_eof_o      (out_eof_o),
		.out_src_rdy_o  (out_src_rdy_o),
		.out_data_o     (out_data_o),
		.load_o         (load),
		.chunk_o        (chunk),
		.busy_i         (busy),
		.digest_valid_i (digest_valid),
		.digest_i       (digest)
	);

	md5_core u_core (
		.clk            (clk),
		.rst            (rst),
		.load_i         (load),
		.chunk_i        (chunk),
		.busy_o         (busy),
		.digest_valid_o (digest_valid),
		.digest_o       (digest)
	);

endmodule

`default_nettype wire

// ==== verilog/md5_channel.sv ====
// MD5 byte stream channel: write and read FSMs, byte shift registers, endian swap
`default_nettype none

module md5_channel (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         wen_i,
	input  wire                         ren_i,
	input  wire                         in_sof_i,
	input  wire                         in_eof_i,
	input  wire                         in_src_rdy_i,
	input  wire  [7:0]                  in_data_i,
	output logic                        in_dst_rdy_o,
	input  wire                         out_dst_rdy_i,
	output logic                        out_sof_o,
	output logic                        out_eof_o,
	output logic                        out_src_rdy_o,
	output logic [7:0]                  out_data_o,
	output logic                        load_o,
	output md5_pkg::md5_chunk_t         chunk_o,
	input  wire                         busy_i,
	input  wire                         digest_valid_i,
	input  wire  md5_pkg::md5_state_t   digest_i
);

	// Byte order swap within a 32-bit word
	function automatic logic [31:0] bswap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	typedef enum logic [1:0] {W_IDLE, W_FILL, W_LOAD, W_WAIT} wstate_t;
	typedef enum logic {R_IDLE, R_SEND} rstate_t;

	wstate_t      wstate;
	wstate_t      wnext;
	rstate_t      rstate;
	logic [3:0]   bcnt;
	logic [1:0]   ccnt;
	logic         newtext;
	logic         dig_seen;
	logic [127:0] in_sr;
	logic [127:0] out_sr;
	logic [3:0]   rcnt;
	logic         accept;
	logic         xfer;

	// --------------------------------------------------
	// Write FSM
	// --------------------------------------------------
	assign in_dst_rdy_o = (wstate == W_FILL);
	assign load_o       = (wstate == W_LOAD);
	assign accept       = in_src_rdy_i & wen_i & in_dst_rdy_o;

	always_comb
	begin
		wnext = wstate;
		case (wstate)
			W_IDLE:
				wnext = W_FILL;
			W_FILL:
				// 16th byte closes the chunk
				if (accept && bcnt == 4'(md5_pkg::MD5_BYTES_PER_CHUNK - 1))
					wnext = W_LOAD;
			W_LOAD:
				if (ccnt == 2'(md5_pkg::MD5_CHUNKS_PER_BLOCK - 1))
					wnext = W_WAIT;
				else
					wnext = W_FILL;
			default:
				// Digest in and its frame drained
				if (dig_seen && rstate == R_IDLE)
					wnext = W_FILL;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wstate   <= W_IDLE;
			bcnt     <= '0;
			ccnt     <= '0;
			newtext  <= 1'b0;
			dig_seen <= 1'b0;
		end
		else
		begin
			wstate <= wnext;
			if (accept)
			begin
				bcnt <= bcnt + 4'd1;
				// Sof only counts on the first byte of a block
				if (bcnt == 4'd0 && ccnt == 2'd0)
					newtext <= in_sof_i;
			end
			if (load_o)
				ccnt <= ccnt + 2'd1;
			if (digest_valid_i)
				dig_seen <= 1'b1;
			else if (wstate == W_WAIT && wnext == W_FILL)
				dig_seen <= 1'b0;
		end
	end

	// Input bytes enter at the bottom, first byte ends on top
	always_ff @(posedge clk)
	begin
		if (accept)
			in_sr <= {in_sr[119:0], in_data_i};
	end

	// Little-endian message words for the core
	always_comb
	begin
		chunk_o.newtext = newtext && (ccnt == 2'd0);
		chunk_o.data    = {bswap(in_sr[127:96]), bswap(in_sr[95:64]),
		                   bswap(in_sr[63:32]), bswap(in_sr[31:0])};
	end

	// --------------------------------------------------
	// Read FSM
	// --------------------------------------------------
	assign xfer = out_src_rdy_o & out_dst_rdy_i & ren_i;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rstate <= R_IDLE;
			rcnt   <= '0;
		end
		else
		begin
			case (rstate)
				R_IDLE:
					if (digest_valid_i)
					begin
						rstate <= R_SEND;
						rcnt   <= 4'(md5_pkg::MD5_BYTES_PER_CHUNK - 1);
					end
				default:
					if (xfer)
					begin
						rcnt <= rcnt - 4'd1;
						// Byte 15 just went out
						if (rcnt == 4'd0)
							rstate <= R_IDLE;
					end
			endcase
		end
	end

	// Digest bytes low byte first within each word
	always_ff @(posedge clk)
	begin
		if (rstate == R_IDLE && digest_valid_i)
			out_sr <= {bswap(digest_i.a), bswap(digest_i.b),
			           bswap(digest_i.c), bswap(digest_i.d)};
		else if (xfer)
			out_sr <= {out_sr[119:0], 8'h00};
	end

	assign out_src_rdy_o = (rstate == R_SEND);
	assign out_sof_o     = (rstate == R_SEND) && (rcnt == 4'(md5_pkg::MD5_BYTES_PER_CHUNK - 1));
	assign out_eof_o     = (rstate == R_SEND) && (rcnt == 4'd0);
	assign out_data_o    = out_sr[127:120];

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// Stalled byte holds until taken
	assert property (@(posedge clk) disable iff (rst)
		out_src_rdy_o && !(out_dst_rdy_i && ren_i) |=> $stable(out_data_o));

	// No chunk while the core compresses
	assert property (@(posedge clk) disable iff (rst) load_o |-> !busy_i);

	// Host frames end on a chunk boundary
	assert property (@(posedge clk) disable iff (rst)
		accept && in_eof_i |-> bcnt == 4'(md5_pkg::MD5_BYTES_PER_CHUNK - 1));

endmodule

`default_nettype wire

// ==== verilog/md5_core.sv ====
// MD5 iterative core: chunk collection, 64-step compression, chaining add
`default_nettype none

module md5_core (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         load_i,
	input  wire  md5_pkg::md5_chunk_t   chunk_i,
	output logic                        busy_o,
	output logic                        digest_valid_o,
	output md5_pkg::md5_state_t         digest_o
);

	// --------------------------------------------------
	// Signals
	// --------------------------------------------------
	logic [32*md5_pkg::MD5_WORDS_PER_BLOCK-1:0] block;
	md5_pkg::md5_state_t chain;
	md5_pkg::md5_state_t work;
	md5_pkg::md5_state_t step_out;
	logic [5:0] step;
	logic       run;
	logic       fin;
	logic [1:0] cnt;
	logic [1:0] cnt_base;
	logic       last_chunk;

	// New text restarts the chunk count at this chunk
	assign cnt_base   = chunk_i.newtext ? 2'd0 : cnt;
	assign last_chunk = (cnt_base == 2'(md5_pkg::MD5_CHUNKS_PER_BLOCK - 1));

	// --------------------------------------------------
	// Block and working registers
	// --------------------------------------------------
	// Oldest chunk ends up in the top bits
	always_ff @(posedge clk)
	begin
		if (load_i)
			block <= {block[$bits(block)-$bits(chunk_i.data)-1:0], chunk_i.data};
	end

	// Working state seeded from the chain on the last chunk
	always_ff @(posedge clk)
	begin
		if (load_i && last_chunk)
			work <= chain;
		else if (run)
			work <= step_out;
	end

	md5_step u_step (
		.step_i  (step),
		.state_i (work),
		.block_i (block),
		.state_o (step_out)
	);

	// --------------------------------------------------
	// Control and chaining
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt   <= '0;
			run   <= 1'b0;
			fin   <= 1'b0;
			step  <= '0;
			chain <= md5_pkg::MD5_INIT_STATE;
		end
		else
		begin
			fin <= 1'b0;
			if (load_i)
			begin
				cnt <= cnt_base + 2'd1;
				// Start of text restores initial values
				if (chunk_i.newtext)
					chain <= md5_pkg::MD5_INIT_STATE;
				if (last_chunk)
				begin
					run  <= 1'b1;
					step <= '0;
				end
			end
			if (run)
			begin
				step <= step + 6'd1;
				// Last step done, add in next cycle
				if (step == 6'(md5_pkg::MD5_STEPS - 1))
				begin
					run <= 1'b0;
					fin <= 1'b1;
				end
			end
			if (fin)
				chain <= digest_o;
		end
	end

	// Running digest is the chain plus the working state
	always_comb
	begin
		digest_o.a = chain.a + work.a;
		digest_o.b = chain.b + work.b;
		digest_o.c = chain.c + work.c;
		digest_o.d = chain.d + work.d;
	end

	assign busy_o         = run;
	assign digest_valid_o = fin;

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// Channel holds chunks back while a block compresses
	assert property (@(posedge clk) disable iff (rst) load_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== verilog/md5_step.sv ====
// MD5 single step: round function, message word select, sine constant add and rotate
`default_nettype none

module md5_step (
	input  wire  [5:0]                                      step_i,
	input  wire  md5_pkg::md5_state_t                       state_i,
	input  wire  [32*md5_pkg::MD5_WORDS_PER_BLOCK-1:0]      block_i,
	output md5_pkg::md5_state_t                             state_o
);

	logic [1:0]  round;
	logic [3:0]  g;
	logic [31:0] f;
	logic [31:0] m;
	logic [31:0] sum;
	logic [63:0] dbl;
	logic [4:0]  s;

	always_comb
	begin
		round = step_i[5:4];
		// Round function and word schedule
		case (round)
			2'd0:
			begin
				f = (state_i.b & state_i.c) | (~state_i.b & state_i.d);
				g = step_i[3:0];
			end
			2'd1:
			begin
				f = (state_i.d & state_i.b) | (~state_i.d & state_i.c);
				g = 4'(step_i * 5 + 1);
			end
			2'd2:
			begin
				f = state_i.b ^ state_i.c ^ state_i.d;
				g = 4'(step_i * 3 + 5);
			end
			default:
			begin
				f = state_i.c ^ (state_i.b | ~state_i.d);
				g = 4'(step_i * 7);
			end
		endcase
		// Word 0 sits in the top bits of the block
		m   = block_i[32*(md5_pkg::MD5_WORDS_PER_BLOCK-1-g) +: 32];
		s   = md5_pkg::MD5_S[{round, step_i[1:0]}];
		sum = state_i.a + f + md5_pkg::MD5_K[step_i] + m;
		// Left rotate via doubled word
		dbl = {sum, sum} << s;
		state_o.a = state_i.d;
		state_o.b = state_i.b + dbl[63:32];
		state_o.c = state_i.b;
		state_o.d = state_i.c;
	end

endmodule

`default_nettype wire

// ==== verilog/md5_pkg.sv ====
// MD5 sizes, initial state, state and chunk structs, sine and rotate tables
`default_nettype none

package md5_pkg;

	// --------------------------------------------------
	// Sizes
	// --------------------------------------------------
	localparam int MD5_WORDS_PER_BLOCK  = 16;
	localparam int MD5_CHUNKS_PER_BLOCK = 4;
	localparam int MD5_BYTES_PER_CHUNK  = 16;
	localparam int MD5_STEPS            = 64;

	// Chaining or working variables
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
	} md5_state_t;

	// Four message words, word 0 in the top bits
	typedef struct packed {
		logic         newtext;
		logic [127:0] data;
	} md5_chunk_t;

	localparam md5_state_t MD5_INIT_STATE = '{
		a: 32'h67452301,
		b: 32'hefcdab89,
		c: 32'h98badcfe,
		d: 32'h10325476
	};

	// --------------------------------------------------
	// Step tables
	// --------------------------------------------------
	// Sine constants, one per step
	localparam logic [31:0] MD5_K [MD5_STEPS] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// Rotate amounts, indexed by round and step within a group of four
	localparam logic [4:0] MD5_S [16] = '{
		5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9,  5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21
	};

endpackage

`default_nettype wire
